// ==== hw/tile_map_pkg.sv ====
package tile_map_pkg;

  // Address map of the tile data side
  // Both windows are inclusive on both bounds

  localparam int unsigned ADDR_W = 32;  // Width of the map constants

  // L1 scratchpad window, 16 KiB at most
  localparam logic [ADDR_W-1:0] L1_ADDR_START = 32'h1000_0000;  // First L1 byte
  localparam logic [ADDR_W-1:0] L1_ADDR_END   = 32'h1000_3FFF;  // Last L1 byte

  // L2 window, leaves the tile through the l2_ port
  localparam logic [ADDR_W-1:0] L2_ADDR_START = 32'h8000_0000;  // First L2 byte
  localparam logic [ADDR_W-1:0] L2_ADDR_END   = 32'h8FFF_FFFF;  // Last L2 byte

  // Target codes carried from router to response merge
  localparam int unsigned TGT_W = 2;  // Width of a target code

  localparam logic [TGT_W-1:0] TGT_L1  = 2'd0;  // Local scratchpad
  localparam logic [TGT_W-1:0] TGT_L2  = 2'd1;  // Outside the tile
  localparam logic [TGT_W-1:0] TGT_ERR = 2'd2;  // Unmapped, answered locally

endpackage

// ==== hw/tile_mem_pkg.sv ====
package tile_mem_pkg;

  // Word and bus widths of the data side
  localparam int unsigned DATA_W = 32;           // Data word
  localparam int unsigned ADDR_W = 32;           // Byte address
  localparam int unsigned BE_W   = DATA_W / 8;   // One enable per byte

  // Scratchpad geometry, word-interleaved over the banks
  localparam int unsigned N_BANKS    = 4;                 // Bank count
  localparam int unsigned BANK_SEL_W = $clog2(N_BANKS);   // Bank index width
  localparam int unsigned BYTE_OFF_W = $clog2(BE_W);      // Byte inside a word
  localparam int unsigned ROW_FLD_W  = ADDR_W - BANK_SEL_W - BYTE_OFF_W;  // Row field

  // Offset into the L1 window
  // Router reads it flat for the range check, the scratchpad splits it
  // Consecutive words land in consecutive banks
  typedef union packed {
    logic [ADDR_W-1:0] flat;              // Byte offset from window start
    struct packed {
      logic [ROW_FLD_W-1:0]  row;         // Row inside the bank
      logic [BANK_SEL_W-1:0] bank;        // Bank index, low word bits
      logic [BYTE_OFF_W-1:0] byte_off;    // Byte lane, ignored by banks
    } fields;
  } l1_addr_u;

endpackage

// ==== hw/tile_clk_gate.sv ====
`timescale 1ns/1ps

module tile_clk_gate (
  input  logic clk_i,      // Free-running tile clock
  input  logic rstn_i,     // Async reset, active low
  input  logic en_i,       // Tile enable request
  input  logic test_en_i,  // Scan bypass, forces the clock on
  output logic clk_o       // Gated clock for the whole tile
);

  logic en_q;       // Enable, sampled on the free clock
  logic en_latch;   // Held through the high phase

  // Only flop of the tile on the ungated clock
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) en_q <= 1'b0;  // Tile starts gated
    else         en_q <= en_i;
  end

  // Transparent while the clock is low, so no glitch on clk_o
  always_latch begin
    if (!clk_i) en_latch = en_q | test_en_i;
  end

  assign clk_o = clk_i & en_latch;  // First pulse one edge after en_q rises

endmodule

// ==== hw/tile_addr_router.sv ====
`timescale 1ns/1ps

module tile_addr_router #(
  parameter int unsigned N_WORDS_BANK = 256  // Rows per scratchpad bank
) (
  input  logic                                     clk_i,
  input  logic                                     rstn_i,
  // Core data port
  input  logic                                     core_req_i,
  input  logic [tile_mem_pkg::ADDR_W-1:0]          core_addr_i,
  input  logic                                     core_we_i,
  input  logic [tile_mem_pkg::BE_W-1:0]            core_be_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]          core_wdata_i,
  output logic                                     core_gnt_o,
  // Scratchpad side
  output logic                                     l1_req_o,
  output tile_mem_pkg::l1_addr_u                   l1_addr_o,
  output logic                                     l1_we_o,
  output logic [tile_mem_pkg::BE_W-1:0]            l1_be_o,
  output logic [tile_mem_pkg::DATA_W-1:0]          l1_wdata_o,
  // L2 side
  output logic                                     l2_req_o,
  output logic [tile_mem_pkg::ADDR_W-1:0]          l2_addr_o,
  output logic                                     l2_we_o,
  output logic [tile_mem_pkg::BE_W-1:0]            l2_be_o,
  output logic [tile_mem_pkg::DATA_W-1:0]          l2_wdata_o,
  input  logic                                     l2_gnt_i,
  // Accepted access, to the response merge
  output logic                                     acc_fire_o,
  output logic [tile_map_pkg::TGT_W-1:0]           acc_tgt_o,
  input  logic                                     l2_pending_i
);

  // Bytes actually backed by the banks, may be smaller than the map window
  localparam logic [tile_mem_pkg::ADDR_W-1:0] L1_SIZE =
    tile_mem_pkg::ADDR_W'(N_WORDS_BANK * tile_mem_pkg::N_BANKS * tile_mem_pkg::BE_W);

  tile_mem_pkg::l1_addr_u              l1_off;   // Offset into the L1 window
  logic                                l1_hit;   // Backed L1 address
  logic                                l2_hit;   // Inside the L2 window
  logic [tile_map_pkg::TGT_W-1:0]      tgt;      // Decoded target
  logic                                l1_sel;
  logic                                l2_sel;

  assign l1_off.flat = core_addr_i - tile_map_pkg::L1_ADDR_START;

  assign l1_hit = (core_addr_i >= tile_map_pkg::L1_ADDR_START) &&
                  (core_addr_i <= tile_map_pkg::L1_ADDR_END) &&
                  (l1_off.flat < L1_SIZE);  // Beyond the banks counts as unmapped
  assign l2_hit = (core_addr_i >= tile_map_pkg::L2_ADDR_START) &&
                  (core_addr_i <= tile_map_pkg::L2_ADDR_END);

  assign tgt = l1_hit ? tile_map_pkg::TGT_L1 :
               l2_hit ? tile_map_pkg::TGT_L2 : tile_map_pkg::TGT_ERR;

  assign l1_sel = (tgt == tile_map_pkg::TGT_L1);
  assign l2_sel = (tgt == tile_map_pkg::TGT_L2);

  // Nothing leaves while an L2 access is open, L2 also waits for its grant
  assign core_gnt_o = core_req_i && !l2_pending_i && (!l2_sel || l2_gnt_i);

  assign acc_fire_o = core_req_i && core_gnt_o;  // Handshake done this cycle
  assign acc_tgt_o  = tgt;

  // Scratchpad always grants, so the strobe is the handshake itself
  assign l1_req_o   = acc_fire_o && l1_sel;
  assign l1_addr_o  = l1_sel ? l1_off : '0;
  assign l1_we_o    = l1_sel && core_we_i;
  assign l1_be_o    = l1_sel ? core_be_i : '0;
  assign l1_wdata_o = l1_sel ? core_wdata_i : '0;

  // Held request towards L2 until l2_gnt_i
  assign l2_req_o   = core_req_i && l2_sel && !l2_pending_i;
  assign l2_addr_o  = l2_sel ? core_addr_i : '0;
  assign l2_we_o    = l2_sel && core_we_i;
  assign l2_be_o    = l2_sel ? core_be_i : '0;
  assign l2_wdata_o = l2_sel ? core_wdata_i : '0;

  // Ungranted L2 request stays up with the same address
  a_l2_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    l2_req_o && !l2_gnt_i |=> l2_req_o && $stable(l2_addr_o));

endmodule

// ==== hw/tile_l1_spm.sv ====
`timescale 1ns/1ps

module tile_l1_spm #(
  parameter int unsigned N_WORDS_BANK = 256  // Rows per bank, power of two
) (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              req_i,    // One access per cycle
  input  tile_mem_pkg::l1_addr_u            addr_i,   // Offset into the window
  input  logic                              we_i,
  input  logic [tile_mem_pkg::BE_W-1:0]     be_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]   wdata_i,
  output logic                              rvalid_o, // One cycle after req_i
  output logic [tile_mem_pkg::DATA_W-1:0]   rdata_o
);

  localparam int unsigned ROW_W = $clog2(N_WORDS_BANK);  // Used row bits

  logic [ROW_W-1:0]                                  row;         // Row inside a bank
  logic [tile_mem_pkg::BANK_SEL_W-1:0]               bank_q;      // Bank of last access
  logic [tile_mem_pkg::N_BANKS-1:0][tile_mem_pkg::DATA_W-1:0] bank_rdata;  // Per-bank output
  logic                                              rvalid_q;

  assign row = addr_i.fields.row[ROW_W-1:0];

  for (genvar g = 0; g < tile_mem_pkg::N_BANKS; g++) begin : gen_bank
    logic [tile_mem_pkg::DATA_W-1:0] mem_q [N_WORDS_BANK];  // Bank storage
    logic [tile_mem_pkg::DATA_W-1:0] rdata_q;               // Registered read port
    logic                            bank_req;

    assign bank_req = req_i && (addr_i.fields.bank == g);   // Interleave on word bits

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        rdata_q <= mem_q[row];  // Old word, also on writes
        if (we_i) begin
          for (int b = 0; b < tile_mem_pkg::BE_W; b++) begin
            if (be_i[b]) mem_q[row][8*b +: 8] <= wdata_i[8*b +: 8];  // Byte lane write
          end
        end
      end
    end

    assign bank_rdata[g] = rdata_q;
  end

  // Bank select follows the read data by one cycle
  always_ff @(posedge clk_i) begin
    if (req_i) bank_q <= addr_i.fields.bank;
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) rvalid_q <= 1'b0;
    else         rvalid_q <= req_i;  // Every access answers, reads and writes
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = bank_rdata[bank_q];

  // Router range check must keep the row inside the bank
  a_row_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_i |-> addr_i.fields.row < N_WORDS_BANK);

endmodule

// ==== hw/tile_rsp_merge.sv ====
`timescale 1ns/1ps

module tile_rsp_merge (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  // Accepted access from the router
  input  logic                              acc_fire_i,
  input  logic [tile_map_pkg::TGT_W-1:0]    acc_tgt_i,
  // Scratchpad response
  input  logic                              l1_rvalid_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]   l1_rdata_i,
  // L2 response
  input  logic                              l2_rvalid_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]   l2_rdata_i,
  input  logic                              l2_err_i,
  output logic                              l2_pending_o,  // Stalls the router
  // Core response
  output logic                              core_rvalid_o,
  output logic [tile_mem_pkg::DATA_W-1:0]   core_rdata_o,
  output logic                              core_err_o
);

  logic                             rsp_vld_q;   // One-cycle response due now
  logic [tile_map_pkg::TGT_W-1:0]   rsp_tgt_q;   // Its target, L1 or error
  logic                             l2_pend_q;   // L2 access granted, not answered
  logic                             sel_l1;
  logic                             sel_err;
  logic                             sel_l2;

  // L1 and error accesses answer exactly one cycle after the grant
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rsp_vld_q <= 1'b0;
      rsp_tgt_q <= tile_map_pkg::TGT_L1;
    end else begin
      rsp_vld_q <= acc_fire_i && (acc_tgt_i != tile_map_pkg::TGT_L2);
      if (acc_fire_i) rsp_tgt_q <= acc_tgt_i;
    end
  end

  // Open from the L2 grant until its rvalid
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i)                                            l2_pend_q <= 1'b0;
    else if (l2_rvalid_i)                                   l2_pend_q <= 1'b0;
    else if (acc_fire_i && acc_tgt_i == tile_map_pkg::TGT_L2) l2_pend_q <= 1'b1;
  end

  assign l2_pending_o = l2_pend_q;

  assign sel_l1  = rsp_vld_q && (rsp_tgt_q == tile_map_pkg::TGT_L1) && l1_rvalid_i;
  assign sel_err = rsp_vld_q && (rsp_tgt_q == tile_map_pkg::TGT_ERR);
  assign sel_l2  = l2_pend_q && l2_rvalid_i;  // Passed through in the same cycle

  assign core_rvalid_o = sel_l1 || sel_err || sel_l2;
  assign core_rdata_o  = sel_l1 ? l1_rdata_i :
                         sel_l2 ? l2_rdata_i : '0;  // Error returns zero
  assign core_err_o    = sel_err || (sel_l2 && l2_err_i);

  // No L2 answer without an open L2 access
  a_l2_rsp_expected: assert property (@(posedge clk_i) disable iff (!rstn_i)
    l2_rvalid_i |-> l2_pending_o);

endmodule

// ==== hw/tile_data_top.sv ====
`timescale 1ns/1ps

module tile_data_top #(
  parameter int unsigned N_WORDS_BANK = 256  // Rows per scratchpad bank
) (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              test_mode_i,    // Clock gate bypass
  input  logic                              tile_enable_i,
  // Core data port
  input  logic                              core_req_i,
  input  logic [tile_mem_pkg::ADDR_W-1:0]   core_addr_i,
  input  logic                              core_we_i,
  input  logic [tile_mem_pkg::BE_W-1:0]     core_be_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]   core_wdata_i,
  output logic                              core_gnt_o,
  output logic                              core_rvalid_o,
  output logic [tile_mem_pkg::DATA_W-1:0]   core_rdata_o,
  output logic                              core_err_o,
  // L2 port
  output logic                              l2_req_o,
  output logic [tile_mem_pkg::ADDR_W-1:0]   l2_addr_o,
  output logic                              l2_we_o,
  output logic [tile_mem_pkg::BE_W-1:0]     l2_be_o,
  output logic [tile_mem_pkg::DATA_W-1:0]   l2_wdata_o,
  input  logic                              l2_gnt_i,
  input  logic                              l2_rvalid_i,
  input  logic [tile_mem_pkg::DATA_W-1:0]   l2_rdata_i,
  input  logic                              l2_err_i
);

  logic                              sys_clk;     // Gated tile clock
  logic                              l1_req;
  tile_mem_pkg::l1_addr_u            l1_addr;
  logic                              l1_we;
  logic [tile_mem_pkg::BE_W-1:0]     l1_be;
  logic [tile_mem_pkg::DATA_W-1:0]   l1_wdata;
  logic                              l1_rvalid;
  logic [tile_mem_pkg::DATA_W-1:0]   l1_rdata;
  logic                              acc_fire;    // Accepted access
  logic [tile_map_pkg::TGT_W-1:0]    acc_tgt;
  logic                              l2_pending;  // Router stall

  tile_clk_gate u_clk_gate (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .en_i      (tile_enable_i),
    .test_en_i (test_mode_i),
    .clk_o     (sys_clk)
  );

  tile_addr_router #(.N_WORDS_BANK(N_WORDS_BANK)) u_router (
    .clk_i (sys_clk), .rstn_i (rstn_i),
    .core_req_i (core_req_i), .core_addr_i (core_addr_i), .core_we_i (core_we_i),
    .core_be_i (core_be_i), .core_wdata_i (core_wdata_i), .core_gnt_o (core_gnt_o),
    .l1_req_o (l1_req), .l1_addr_o (l1_addr), .l1_we_o (l1_we),
    .l1_be_o (l1_be), .l1_wdata_o (l1_wdata),
    .l2_req_o (l2_req_o), .l2_addr_o (l2_addr_o), .l2_we_o (l2_we_o),
    .l2_be_o (l2_be_o), .l2_wdata_o (l2_wdata_o), .l2_gnt_i (l2_gnt_i),
    .acc_fire_o (acc_fire), .acc_tgt_o (acc_tgt), .l2_pending_i (l2_pending)
  );

  tile_l1_spm #(.N_WORDS_BANK(N_WORDS_BANK)) u_l1_spm (
    .clk_i (sys_clk), .rstn_i (rstn_i),
    .req_i (l1_req), .addr_i (l1_addr), .we_i (l1_we), .be_i (l1_be),
    .wdata_i (l1_wdata), .rvalid_o (l1_rvalid), .rdata_o (l1_rdata)
  );

  tile_rsp_merge u_rsp_merge (
    .clk_i (sys_clk), .rstn_i (rstn_i),
    .acc_fire_i (acc_fire), .acc_tgt_i (acc_tgt),
    .l1_rvalid_i (l1_rvalid), .l1_rdata_i (l1_rdata),
    .l2_rvalid_i (l2_rvalid_i), .l2_rdata_i (l2_rdata_i), .l2_err_i (l2_err_i),
    .l2_pending_o (l2_pending),
    .core_rvalid_o (core_rvalid_o), .core_rdata_o (core_rdata_o), .core_err_o (core_err_o)
  );

endmodule

// ==== testbench/tb_tile_data.sv ====
`timescale 1ns/1ps

module tb_tile_data;

  localparam int          CLK_HALF   = 10;             // 20 ns period
  localparam int          SAMPLE_DLY = 9;              // Just before the rising edge
  localparam int          TIMEOUT    = 50;             // Cycles per wait loop
  localparam int          DIS_CYCLES = 10;             // Cycles with the tile gated off
  localparam logic [31:0] RAND_SEED  = 32'h7e80dbb5;
  localparam logic [31:0] L2_XOR     = 32'hA5A5_A5A5;  // L2 model read pattern

  logic        clk_i, rstn_i, test_mode_i, tile_enable_i;
  logic        core_req_i, core_we_i, core_gnt_o, core_rvalid_o, core_err_o;
  logic [3:0]  core_be_i, l2_be_o;
  logic [31:0] core_addr_i, core_wdata_i, core_rdata_o;
  logic        l2_req_o, l2_we_o, l2_gnt_i, l2_rvalid_i, l2_err_i;
  logic [31:0] l2_addr_o, l2_wdata_o, l2_rdata_i;

  int          err_cnt, test_cnt, fail_cnt;   // Totals for the closing line
  bit          timed_out;                     // Stops the stimulus loop
  bit          l2_busy, l2_need_draw;         // L2 model state
  int          l2_gnt_cnt, l2_rsp_cnt;        // Cycles left to grant, to answer
  logic [31:0] l2_addr_q;                     // Address of the open L2 access
  bit          l2_taken;                      // Set at each L2 handshake
  logic        l2_we_q;                       // Fields seen at the last L2 handshake
  logic [3:0]  l2_be_q;
  logic [31:0] l2_wdata_q;

  tile_data_top #(.N_WORDS_BANK(256)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // L2 responder, grants after 0 to 3 waiting cycles, answers 1 to 4 cycles later
  initial begin
    l2_gnt_i     = 1'b0;
    l2_rvalid_i  = 1'b0;
    l2_rdata_i   = '0;
    l2_err_i     = 1'b0;   // Never errors
    l2_busy      = 1'b0;
    l2_need_draw = 1'b1;
    l2_addr_q    = '0;
    l2_taken     = 1'b0;
    l2_we_q      = 1'b0;
    l2_be_q      = '0;
    l2_wdata_q   = '0;
    forever begin
      @(negedge clk_i);
      l2_rvalid_i = 1'b0;
      l2_rdata_i  = '0;
      if (l2_busy) begin
        l2_rsp_cnt--;
        if (l2_rsp_cnt == 0) begin       // Answer now
          l2_rvalid_i  = 1'b1;
          l2_rdata_i   = l2_addr_q ^ L2_XOR;
          l2_busy      = 1'b0;
          l2_need_draw = 1'b1;
        end
      end
      if (l2_need_draw) begin
        l2_gnt_cnt   = $urandom % 4;     // Grant delay of the next access
        l2_need_draw = 1'b0;
      end
      l2_gnt_i = !l2_busy && (l2_gnt_cnt == 0);
      #SAMPLE_DLY;
      if (l2_req_o && !l2_busy) begin
        if (l2_gnt_i) begin              // Handshake at this edge
          l2_busy    = 1'b1;
          l2_addr_q  = l2_addr_o;
          l2_taken   = 1'b1;
          l2_we_q    = l2_we_o;
          l2_be_q    = l2_be_o;
          l2_wdata_q = l2_wdata_o;
          l2_rsp_cnt = 1 + $urandom % 4;
        end else begin
          l2_gnt_cnt--;
        end
      end
    end
  end

  function automatic bit in_l2_window(input logic [31:0] addr);
    return (addr >= 32'h8000_0000) && (addr <= 32'h8FFF_FFFF);
  endfunction

  // One core access, lat counts cycles from grant to rvalid
  task automatic do_access(input bit we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, output logic [31:0] rdata,
                           output logic err, output int lat, output bit ok);
    int cyc;
    bit done;
    cyc  = 0;
    done = 1'b0;
    ok   = 1'b0;
    lat  = 1;
    @(negedge clk_i);
    core_req_i   = 1'b1;
    core_addr_i  = addr;
    core_we_i    = we;
    core_be_i    = be;
    core_wdata_i = wdata;
    while (!done && cyc < TIMEOUT) begin
      #SAMPLE_DLY;
      if (core_gnt_o) done = 1'b1;
      else cyc++;
      @(negedge clk_i);
    end
    core_req_i = 1'b0;      // Request taken or abandoned
    core_we_i  = 1'b0;
    if (!done) begin
      $display("No grant for address %h within %0d cycles", addr, TIMEOUT);
    end else begin
      done = 1'b0;
      while (!done && lat <= TIMEOUT) begin
        #SAMPLE_DLY;
        if (core_rvalid_o) begin
          done  = 1'b1;
          rdata = core_rdata_o;
          err   = core_err_o;
        end else begin
          lat++;
          @(negedge clk_i);
        end
      end
      ok = done;
      if (!done) $display("No response for address %h within %0d cycles", addr, TIMEOUT);
    end
  endtask

  // Request fields seen on the L2 port against the core access
  task automatic check_l2_fields(input bit we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] be);
    if (in_l2_window(addr) != l2_taken) begin
      $display("L2 request for address %h was %s", addr, l2_taken ? "unexpected" : "missing");
      err_cnt++;
    end else if (l2_taken) begin
      if (l2_addr_q !== addr) begin
        $display("MISMATCH l2_addr_o: got %h expected %h", l2_addr_q, addr);
        err_cnt++;
      end
      if (l2_we_q !== we) begin
        $display("MISMATCH l2_we_o addr %h: got %h expected %h", addr, l2_we_q, we);
        err_cnt++;
      end
      if (l2_be_q !== be) begin
        $display("MISMATCH l2_be_o addr %h: got %h expected %h", addr, l2_be_q, be);
        err_cnt++;
      end
      if (we && l2_wdata_q !== wdata) begin
        $display("MISMATCH l2_wdata_o addr %h: got %h expected %h", addr, l2_wdata_q, wdata);
        err_cnt++;
      end
    end
  endtask

  // Tile gated off, no grant and no response may appear
  task automatic check_tile_disabled();
    int cyc;
    @(negedge clk_i);
    tile_enable_i = 1'b0;
    for (cyc = 0; cyc < DIS_CYCLES; cyc++) begin
      #SAMPLE_DLY;
      if (core_gnt_o || core_rvalid_o) begin
        $display("Tile answered in cycle %0d while disabled", cyc);
        err_cnt++;
      end
      @(negedge clk_i);
    end
    tile_enable_i = 1'b1;
    repeat (2) @(negedge clk_i);  // Gated clock restarts
  endtask

  task automatic run_test(input logic [7:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be,
                          input logic [31:0] exp_rdata, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    int          lat;
    bit          ok;
    int          errs_before;
    errs_before = err_cnt;
    test_cnt++;
    if (op == "D") begin
      check_tile_disabled();
    end else if (op == "W" || op == "R") begin
      l2_taken = 1'b0;
      do_access(op == "W", addr, wdata, be, rdata, err, lat, ok);
      if (!ok) begin
        timed_out = 1'b1;
        err_cnt++;
      end else begin
        if (!in_l2_window(addr) && lat != 1) begin   // L1 and error answer next cycle
          $display("Response to address %h came %0d cycles after the grant, not 1", addr, lat);
          err_cnt++;
        end
        if (err !== exp_err) begin
          $display("MISMATCH core_err_o addr %h: got %h expected %h", addr, err, exp_err);
          err_cnt++;
        end
        if ((op == "R" || exp_err) && rdata !== exp_rdata) begin
          $display("MISMATCH core_rdata_o addr %h: got %h expected %h", addr, rdata, exp_rdata);
          err_cnt++;
        end
        check_l2_fields(op == "W", addr, wdata, be);
      end
    end else begin
      $display("Unknown operation %s in the stimulus file", op);
      err_cnt++;
    end
    if (err_cnt == errs_before) begin
      $display("Test %0d %s %h: ok", test_cnt, op, addr);
    end else begin
      $display("Test %0d %s %h: FAILED", test_cnt, op, addr);
      fail_cnt++;
    end
  endtask

  initial begin
    int                fd, rc;
    bit                done;
    logic [7:0]        tok;                          // Operation letter or comment mark
    logic [8*120-1:0]  skip_buf;
    logic [31:0]       f_addr, f_wdata, f_rdata;
    logic [3:0]        f_be, f_err;
    void'($urandom(RAND_SEED));
    rstn_i        = 1'b0;
    test_mode_i   = 1'b0;
    tile_enable_i = 1'b1;
    core_req_i    = 1'b0;
    core_addr_i   = '0;
    core_we_i     = 1'b0;
    core_be_i     = '0;
    core_wdata_i  = '0;
    err_cnt       = 0;
    test_cnt      = 0;
    fail_cnt      = 0;
    timed_out     = 1'b0;
    done          = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    repeat (3) @(negedge clk_i);   // Enable reaches the gate
    fd = $fopen("testbench/tile_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file testbench/tile_stim.txt");
      err_cnt++;
      done = 1'b1;
    end
    while (!done) begin
      if ($fscanf(fd, "%s", tok) != 1) begin
        done = 1'b1;                               // End of file
      end else if (tok == "#") begin
        rc = $fgets(skip_buf, fd);                 // Rest of a comment line
      end else begin
        rc = $fscanf(fd, "%h %h %h %h %h", f_addr, f_wdata, f_be, f_rdata, f_err);
        if (rc != 5) begin
          $display("Stimulus line after test %0d is incomplete", test_cnt);
          err_cnt++;
          done = 1'b1;
        end else begin
          run_test(tok, f_addr, f_wdata, f_be, f_rdata, f_err[0]);
          done = timed_out;
        end
      end
    end
    if (fd != 0) $fclose(fd);
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tile_stim.txt ====
# op addr wdata be exp_rdata exp_err, all values hex
# op W write, R read, D tile disabled for 10 cycles
W 10000000 11111111 f 0 0
W 10000004 22222222 f 0 0
W 10000008 33333333 f 0 0
W 1000000c 44444444 f 0 0
W 10000ff0 deadbeef f 0 0
R 10000000 0 f 11111111 0
R 10000004 0 f 22222222 0
R 10000008 0 f 33333333 0
R 1000000c 0 f 44444444 0
R 10000ff0 0 f deadbeef 0
W 10000004 0000aa00 2 0 0
W 10000008 cc0000dd 9 0 0
R 10000004 0 f 2222aa22 0
R 10000008 0 f cc3333dd 0
R 80000000 0 f 25a5a5a5 0
R 80001234 0 f 25a5b791 0
W 80000010 12345678 f 0 0
R 8ffffffc 0 f 2a5a5a59 0
R 20000000 0 f 0 1
W 00000000 ffffffff f 0 1
R 10001000 0 f 0 1
D 0 0 0 0 0
R 10000000 0 f 11111111 0
R 10000ff0 0 f deadbeef 0

// ==== sim.f ====
hw/tile_map_pkg.sv
hw/tile_mem_pkg.sv
hw/tile_clk_gate.sv
hw/tile_addr_router.sv
hw/tile_l1_spm.sv
hw/tile_rsp_merge.sv
hw/tile_data_top.sv
testbench/tb_tile_data.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_tile_data -Mdir obj_dir
	./obj_dir/Vtb_tile_data > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
